/* Makefile */
TOP := tb_etx_core

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -Mdir obj_dir -f sim.f

run: build
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q "Result: FAILED" sim.log; then \
		echo "simulation reported failure"; exit 1; \
	fi
	@if ! grep -q "Result: PASSED" sim.log; then \
		echo "simulation ended without a result"; exit 1; \
	fi

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f sim.f

clean:
	rm -rf obj_dir sim.log

/* hdl/etx_core.sv */
module etx_core
   import etx_pkg::*;
(
   input  logic          clk,
   input  logic          nreset,
   input  logic          tx_enable,
   // System side
   input  logic          etx_access,
   input  emesh_packet_t etx_packet,
   output logic          sys_wait,
   // Link side
   input  logic          io_wr_wait,
   input  logic          io_rd_wait,
   output logic          io_valid,
   output logic          io_start,
   output logic [7:0]    io_data
);

   // Queue to controller
   logic          fifo_valid;
   emesh_packet_t fifo_packet;
   logic          etx_wr_wait;
   logic          etx_rd_wait;

   // Controller to serializer
   logic          tx_access;
   logic          tx_burst;
   emesh_packet_t tx_packet;
   logic          tx_wr_wait;
   logic          tx_rd_wait;

   //####################
   // Input queue
   //####################

   etx_fifo u_etx_fifo (
      .clk         (clk),
      .nreset      (nreset),
      .etx_access  (etx_access),
      .etx_packet  (etx_packet),
      .sys_wait    (sys_wait),
      .etx_wr_wait (etx_wr_wait),
      .etx_rd_wait (etx_rd_wait),
      .fifo_valid  (fifo_valid),
      .fifo_packet (fifo_packet)
   );

   //####################
   // Protocol control
   //####################

   etx_protocol u_etx_protocol (
      .clk         (clk),
      .nreset      (nreset),
      .tx_enable   (tx_enable),
      .fifo_valid  (fifo_valid),
      .fifo_packet (fifo_packet),
      .etx_wr_wait (etx_wr_wait),
      .etx_rd_wait (etx_rd_wait),
      .tx_wr_wait  (tx_wr_wait),
      .tx_rd_wait  (tx_rd_wait),
      .tx_access   (tx_access),
      .tx_burst    (tx_burst),
      .tx_packet   (tx_packet)
   );

   //####################
   // Byte serializer
   //####################

   etx_serializer u_etx_serializer (
      .clk        (clk),
      .nreset     (nreset),
      .tx_access  (tx_access),
      .tx_burst   (tx_burst),
      .tx_packet  (tx_packet),
      .tx_wr_wait (tx_wr_wait),
      .tx_rd_wait (tx_rd_wait),
      .io_wr_wait (io_wr_wait),
      .io_rd_wait (io_rd_wait),
      .io_valid   (io_valid),
      .io_start   (io_start),
      .io_data    (io_data)
   );

endmodule

/* hdl/etx_fifo.sv */
module etx_fifo
   import etx_pkg::*;
(
   input  logic          clk,
   input  logic          nreset,
   // System write side
   input  logic          etx_access,
   input  emesh_packet_t etx_packet,
   output logic          sys_wait,
   // Controller side
   input  logic          etx_wr_wait,
   input  logic          etx_rd_wait,
   output logic          fifo_valid,
   output emesh_packet_t fifo_packet
);

   // Packet storage
   emesh_packet_t      mem [FIFO_DEPTH];
   logic [FIFO_AW-1:0] wr_ptr;
   logic [FIFO_AW-1:0] rd_ptr;
   logic [FIFO_AW:0]   count;
   logic               push;
   logic               pop;
   logic               head_wait;

   //####################
   // Status
   //####################

   assign sys_wait    = (count == (FIFO_AW + 1)'(FIFO_DEPTH));
   assign fifo_valid  = (count != '0);
   assign fifo_packet = mem[rd_ptr];

   // Wait level that matches the head's kind
   assign head_wait = fifo_packet.write ? etx_wr_wait : etx_rd_wait;

   assign push = etx_access & ~sys_wait;
   assign pop  = fifo_valid & ~head_wait;

   //####################
   // Pointers
   //####################

   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         // Pointers wrap naturally at depth 4
         if (push)
            wr_ptr <= wr_ptr + 1'b1;
         if (pop)
            rd_ptr <= rd_ptr + 1'b1;
         // Simultaneous push and pop leaves count alone
         if (push && !pop)
            count <= count + 1'b1;
         else if (pop && !push)
            count <= count - 1'b1;
      end
   end

   // Write port
   always_ff @(posedge clk)
   begin
      if (push)
         mem[wr_ptr] <= etx_packet;
   end

endmodule

/* hdl/etx_pkg.sv */
package etx_pkg;

   //####################
   // Mesh packet
   //####################

   // 104 bits, MSB field first
   typedef struct packed {
      logic        write;
      logic [1:0]  datamode;
      logic [3:0]  ctrlmode;
      logic [31:0] dstaddr;
      logic [31:0] data;
      logic [31:0] srcaddr;
      // Always zero
      logic        spare;
   } emesh_packet_t;

   // Datamode for a 64-bit transfer
   localparam logic [1:0] DMODE_DOUBLE = 2'd3;

   //####################
   // Link header byte
   //####################

   // First byte of a full packet
   typedef struct packed {
      logic [3:0] ctrlmode;
      logic [1:0] datamode;
      logic       write;
      logic       zero;
   } tx_header_t;

   //####################
   // Sizes
   //####################

   // Input queue
   localparam int FIFO_DEPTH = 4;
   localparam int FIFO_AW    = 2;

   // Bytes per full packet and per burst beat
   localparam int PKT_BYTES   = 13;
   localparam int BURST_BYTES = 8;
   localparam int CNT_W       = 4;

   // Address step between burst beats
   localparam int BURST_STRIDE = 8;

endpackage

/* hdl/etx_protocol.sv */
module etx_protocol
   import etx_pkg::*;
(
   input  logic          clk,
   input  logic          nreset,
   input  logic          tx_enable,
   // Queue side
   input  logic          fifo_valid,
   input  emesh_packet_t fifo_packet,
   output logic          etx_wr_wait,
   output logic          etx_rd_wait,
   // Serializer side
   input  logic          tx_wr_wait,
   input  logic          tx_rd_wait,
   output logic          tx_access,
   output logic          tx_burst,
   output emesh_packet_t tx_packet
);

   logic        hold_valid;
   logic        head_wait;
   logic        load;
   // Burst history of the last packet held
   logic [31:0] last_addr;
   logic        last_burst_type;
   logic        head_burst_type;
   logic        addr_match;
   logic        burst_in;

   //####################
   // Hand-off
   //####################

   // Held packet leaves once the serializer is free for its kind
   assign tx_access = hold_valid &
                      ~(tx_packet.write ? tx_wr_wait : tx_rd_wait);

   //####################
   // Wait propagation
   //####################

   // Stuck held packet or busy serializer pushes back on the queue
   assign etx_wr_wait = ~tx_enable | (hold_valid & ~tx_access) | tx_wr_wait;
   assign etx_rd_wait = ~tx_enable | (hold_valid & ~tx_access) | tx_rd_wait;

   // Same decision the queue makes for its pop
   assign head_wait = fifo_packet.write ? etx_wr_wait : etx_rd_wait;
   assign load      = fifo_valid & ~head_wait;

   //####################
   // Burst detection
   //####################

   // 64-bit write with default ctrlmode
   assign head_burst_type = fifo_packet.write &
                            (fifo_packet.datamode == DMODE_DOUBLE) &
                            (fifo_packet.ctrlmode == 4'h0);

   // Head must sit one stride above the previous packet
   assign addr_match = (fifo_packet.dstaddr == last_addr + 32'(BURST_STRIDE));

   assign burst_in = head_burst_type & last_burst_type & addr_match;

   //####################
   // Holding register
   //####################

   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         hold_valid      <= 1'b0;
         tx_burst        <= 1'b0;
         last_burst_type <= 1'b0;
      end
      else if (load)
      begin
         // New packet replaces one going out on this edge
         hold_valid      <= 1'b1;
         tx_burst        <= burst_in;
         last_burst_type <= head_burst_type;
      end
      else if (tx_access)
      begin
         hold_valid <= 1'b0;
         tx_burst   <= 1'b0;
      end
   end

   // Payload and address history
   always_ff @(posedge clk)
   begin
      if (load)
      begin
         tx_packet <= fifo_packet;
         last_addr <= fifo_packet.dstaddr;
      end
   end

endmodule

/* hdl/etx_serializer.sv */
module etx_serializer
   import etx_pkg::*;
(
   input  logic          clk,
   input  logic          nreset,
   // Controller side
   input  logic          tx_access,
   input  logic          tx_burst,
   input  emesh_packet_t tx_packet,
   output logic          tx_wr_wait,
   output logic          tx_rd_wait,
   // Link side
   input  logic          io_wr_wait,
   input  logic          io_rd_wait,
   output logic          io_valid,
   output logic          io_start,
   output logic [7:0]    io_data
);

   localparam int SR_W = PKT_BYTES * 8;

   logic [SR_W-1:0]  shift_reg;
   logic [CNT_W-1:0] count;
   tx_header_t       header;
   logic             busy;
   logic             stall;
   logic             last;
   logic             done;

   //####################
   // Header byte
   //####################

   assign header.ctrlmode = tx_packet.ctrlmode;
   assign header.datamode = tx_packet.datamode;
   assign header.write    = tx_packet.write;
   assign header.zero     = 1'b0;

   //####################
   // Byte output
   //####################

   assign busy  = (count != '0);
   assign last  = (count == CNT_W'(1));
   // Either remote wait freezes the stream
   assign stall = io_wr_wait | io_rd_wait;

   assign io_valid = busy & ~stall;
   assign io_data  = shift_reg[SR_W-1 -: 8];

   // Only a full packet starts at the full count
   assign io_start = io_valid & (count == CNT_W'(PKT_BYTES));

   // Last byte leaves on this edge
   assign done = last & io_valid;

   //####################
   // Wait to controller
   //####################

   // Stalled last byte still blocks the next load
   assign tx_wr_wait = (busy & ~done) | io_wr_wait;
   assign tx_rd_wait = (busy & ~done) | io_rd_wait;

   //####################
   // Byte counter
   //####################

   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
         count <= '0;
      else if (tx_access)
      begin
         if (tx_burst)
            count <= CNT_W'(BURST_BYTES);
         else
            count <= CNT_W'(PKT_BYTES);
      end
      else if (io_valid)
         count <= count - 1'b1;
   end

   //####################
   // Shift register
   //####################

   always_ff @(posedge clk)
   begin
      if (tx_access)
      begin
         if (tx_burst)
         begin
            // Continuation carries data and source only
            shift_reg <= {tx_packet.data, tx_packet.srcaddr, 40'h0};
         end
         else
         begin
            shift_reg <= {header,
                          tx_packet.dstaddr,
                          tx_packet.data,
                          tx_packet.srcaddr};
         end
      end
      else if (io_valid)
      begin
         // MSB byte first
         shift_reg <= {shift_reg[SR_W-9:0], 8'h00};
      end
   end

endmodule

/* sim.f */
hdl/etx_pkg.sv
hdl/etx_fifo.sv
hdl/etx_protocol.sv
hdl/etx_serializer.sv
hdl/etx_core.sv
testbench/tb_etx_core.sv

/* testbench/tb_etx_core.sv */
module tb_etx_core
   import etx_pkg::*;
();

   timeunit 1ns;
   timeprecision 1ps;

   localparam int NUM_PKTS   = 300;
   // 20 cycles per packet covers 13 bytes plus random stalls
   localparam int MAX_CYCLES = NUM_PKTS * 20;

   logic          clk;
   logic          nreset;
   logic          tx_enable;
   logic          etx_access;
   emesh_packet_t etx_packet;
   logic          sys_wait;
   logic          io_wr_wait;
   logic          io_rd_wait;
   logic          io_valid;
   logic          io_start;
   logic [7:0]    io_data;

   // Expected stream of {first byte, start flag, data} entries
   logic [9:0]    exp_q [$];
   logic [9:0]    exp_entry;
   logic [31:0]   lfsr = 32'd68;
   emesh_packet_t gen_prev = '0;
   emesh_packet_t new_pkt;
   // Model burst history
   emesh_packet_t last_pkt = '0;
   logic          last_valid = 1'b0;
   logic          pkt_taken = 1'b0;
   logic          stim_on = 1'b0;
   logic [31:0]   r;
   int            errors = 0;
   int            accepted = 0;
   int            generated = 0;
   int            pkts_started = 0;
   int            bytes_seen = 0;
   int            bursts_seen = 0;
   int            full_cycles = 0;
   int            dis_starts = 0;
   int            cycles = 0;
   int            wr_left = 0;
   int            rd_left = 0;
   int            en_left = 0;

   etx_core u_etx_core (.*);

   initial
   begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   //####################
   // Random source
   //####################

   // Right-shifting Galois form of x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      if (s[0])
         return (s >> 1) ^ 32'h8020_0003;
      return s >> 1;
   endfunction

   // One LFSR step per bit taken
   task automatic draw(input int n, output logic [31:0] v);
      v = '0;
      for (int i = 0; i < n; i++)
      begin
         v    = {v[30:0], lfsr[0]};
         lfsr = lfsr_next(lfsr);
      end
   endtask

   task automatic make_packet(output emesh_packet_t p);
      logic [31:0] v;
      p = '0;
      draw(3, v);
      if (v < 3)
      begin
         // Next beat of a 64-bit write chain
         p.write    = 1'b1;
         p.datamode = DMODE_DOUBLE;
         p.dstaddr  = gen_prev.dstaddr + BURST_STRIDE;
      end
      else
      begin
         draw(1, v);
         p.write = v[0];
         draw(2, v);
         p.datamode = v[1:0];
         draw(4, v);
         p.ctrlmode = v[3:0];
         draw(32, v);
         p.dstaddr = v;
      end
      draw(32, v);
      p.data = v;
      draw(32, v);
      p.srcaddr = v;
      gen_prev = p;
   endtask

   //####################
   // Reference model
   //####################

   task automatic expand(input emesh_packet_t p);
      logic cur_type;
      logic burst;
      cur_type = p.write && (p.datamode == 2'd3) && (p.ctrlmode == 4'h0);
      burst    = last_valid && cur_type && (last_pkt.write && (last_pkt.datamode == 2'd3)
                 && (last_pkt.ctrlmode == 4'h0)) && (p.dstaddr == last_pkt.dstaddr + 8);
      if (!burst)
      begin
         // Header byte of ctrlmode, datamode, write and zero
         exp_q.push_back({2'b11, p.ctrlmode, p.datamode, p.write, 1'b0});
         for (int i = 3; i >= 0; i--)
            exp_q.push_back({2'b00, p.dstaddr[i*8 +: 8]});
      end
      for (int i = 3; i >= 0; i--)
         exp_q.push_back({(burst && i == 3), 1'b0, p.data[i*8 +: 8]});
      for (int i = 3; i >= 0; i--)
         exp_q.push_back({2'b00, p.srcaddr[i*8 +: 8]});
      last_pkt   = p;
      last_valid = 1'b1;
   endtask

   task automatic report_mismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] exp);
      $display("error at %0t ns: %s got %0h expected %0h", $time, name, got, exp);
      errors++;
   endtask

   //####################
   // Stimulus
   //####################

   always @(posedge clk)
   begin
      if (stim_on)
      begin
         // Offer a new packet once the last one was taken
         if ((pkt_taken || !etx_access) && generated < NUM_PKTS)
         begin
            draw(1, r);
            etx_access <= r[0];
            if (r[0])
            begin
               make_packet(new_pkt);
               etx_packet <= new_pkt;
               generated++;
            end
         end
         else if (pkt_taken)
            etx_access <= 1'b0;
         // Remote waits in rare runs of 1 to 16 cycles
         if (wr_left != 0)
            wr_left--;
         else
         begin
            draw(6, r);
            if (r == 0)
            begin
               draw(4, r);
               wr_left = r + 1;
            end
         end
         if (rd_left != 0)
            rd_left--;
         else
         begin
            draw(6, r);
            if (r == 0)
            begin
               draw(4, r);
               rd_left = r + 1;
            end
         end
         // Transmit enable drops even more rarely, for 17 to 48 cycles
         if (en_left != 0)
            en_left--;
         else
         begin
            draw(8, r);
            if (r == 0)
            begin
               draw(5, r);
               en_left = r + 17;
            end
         end
         io_wr_wait <= (wr_left != 0);
         io_rd_wait <= (rd_left != 0);
         tx_enable  <= (en_left == 0);
      end
   end

   //####################
   // Checker
   //####################

   // Outputs settle by the falling edge
   always @(negedge clk)
   begin
      if (!nreset)
      begin
         pkt_taken = 1'b0;
         if (io_valid !== 1'b0)
            report_mismatch("io_valid", io_valid, 0);
         if (io_start !== 1'b0)
            report_mismatch("io_start", io_start, 0);
         if (sys_wait !== 1'b0)
            report_mismatch("sys_wait", sys_wait, 0);
      end
      else
      begin
         // Full queue needs that many packets not yet started
         if (sys_wait && (accepted - pkts_started) < FIFO_DEPTH)
         begin
            $display("sys_wait high at %0t ns with only %0d packets waiting",
                     $time, accepted - pkts_started);
            errors++;
         end
         pkt_taken = etx_access && !sys_wait;
         if (pkt_taken)
         begin
            expand(etx_packet);
            accepted++;
         end
         if (sys_wait)
            full_cycles++;
         if (tx_enable)
            dis_starts = 0;
         // Stalled link must show no byte
         if ((io_wr_wait || io_rd_wait) && io_valid !== 1'b0)
            report_mismatch("io_valid", io_valid, 0);
         if (io_valid && exp_q.size() == 0)
         begin
            $display("byte %0h at %0t ns sent with no packet pending", io_data, $time);
            errors++;
         end
         else if (io_valid)
         begin
            exp_entry = exp_q.pop_front();
            bytes_seen++;
            if (io_data !== exp_entry[7:0])
               report_mismatch("io_data", io_data, exp_entry[7:0]);
            if (io_start !== exp_entry[8])
               report_mismatch("io_start", io_start, exp_entry[8]);
            if (exp_entry[9])
               pkts_started++;
            if (exp_entry[9] && !exp_entry[8])
               bursts_seen++;
            // Only the shifting and the held packet may start
            if (exp_entry[9] && !tx_enable)
            begin
               dis_starts++;
               if (dis_starts == 3)
               begin
                  $display("packet started at %0t ns after tx_enable was low", $time);
                  errors++;
               end
            end
         end
         else if (io_start !== 1'b0)
            report_mismatch("io_start", io_start, 0);
      end
   end

   always @(posedge clk)
   begin
      cycles++;
      if (cycles >= MAX_CYCLES)
      begin
         $display("timeout after %0d cycles, %0d bytes never sent", cycles, exp_q.size());
         $display("Result: FAILED");
         $finish;
      end
   end

   //####################
   // Run control
   //####################

   initial
   begin
      nreset     = 1'b0;
      tx_enable  = 1'b0;
      etx_access = 1'b0;
      etx_packet = '0;
      io_wr_wait = 1'b0;
      io_rd_wait = 1'b0;
      repeat (16) @(posedge clk);
      nreset    <= 1'b1;
      tx_enable <= 1'b1;
      stim_on   <= 1'b1;
      // Drain every accepted packet
      while (!(accepted == NUM_PKTS && exp_q.size() == 0))
         @(posedge clk);
      repeat (20) @(posedge clk);
      if (bursts_seen == 0)
      begin
         $display("no burst continuation was ever sent");
         errors++;
      end
      if (full_cycles == 0)
      begin
         $display("queue never filled, sys_wait stayed low");
         errors++;
      end
      $display("packets %0d bytes %0d bursts %0d full cycles %0d errors %0d",
               accepted, bytes_seen, bursts_seen, full_cycles, errors);
      if (errors == 0)
         $display("Result: PASSED");
      else
         $display("Result: FAILED");
      $finish;
   end

endmodule
